//--- busPkg.sv
package busPkg;

    // bus widths
    localparam int DATA_WIDTH        = 32;
    localparam int ADDR_WIDTH        = 32;
    localparam int WORD_OFFSET_WIDTH = 21;

    // offset widths of the fast peripherals
    localparam int RAM_OFFSET_WIDTH    = 12;
    localparam int RANDOM_OFFSET_WIDTH = 1;
    localparam int TIMER_OFFSET_WIDTH  = 3;
    localparam int IO_OFFSET_WIDTH     = 1;

    typedef enum logic [2:0] {
        TARGET_NONE,
        TARGET_RAM,
        TARGET_RANDOM,
        TARGET_TIMER,
        TARGET_SLOW,
        TARGET_IO
    } busTarget_e;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_READ_WAIT,
        STATE_SLOW_WAIT
    } busState_e;

    // memory map, inclusive byte ranges
    localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
    localparam logic [31:0] RAM_LAST    = 32'h0000_3FFF;
    localparam logic [31:0] RANDOM_BASE = 32'h0000_5000;
    localparam logic [31:0] RANDOM_LAST = 32'h0000_5003;
    localparam logic [31:0] TIMER_BASE  = 32'h0000_5100;
    localparam logic [31:0] TIMER_LAST  = 32'h0000_511F;
    localparam logic [31:0] SLOW_BASE   = 32'h0100_0000;
    localparam logic [31:0] SLOW_LAST   = 32'h017F_FFFF;
    localparam logic [31:0] IO_BASE     = 32'h0300_0000;
    localparam logic [31:0] IO_LAST     = 32'h0300_0003;

    localparam logic [31:0] UNMAPPED_READ_VALUE = 32'hBADB_ADBA;

    // timer register offsets
    localparam logic [2:0] TIMER_CONTROL = 3'd0;
    localparam logic [2:0] TIMER_COUNT   = 3'd1;
    localparam logic [2:0] TIMER_COMPARE = 3'd2;
    localparam logic [2:0] TIMER_STATUS  = 3'd3;

endpackage

//--- peripheralBus.sv
`timescale 1ns/100ps

interface peripheralBus #(
    parameter int OFFSET_WIDTH = 1
);
    import busPkg::*;

    // one-cycle strobes from the controller
    logic                    read;
    logic                    write;
    logic [OFFSET_WIDTH-1:0] offset;
    logic [DATA_WIDTH-1:0]   writeData;
    // registered by the peripheral at the end of the read strobe
    logic [DATA_WIDTH-1:0]   readData;

    modport controller (
        output read,
        output write,
        output offset,
        output writeData,
        input  readData
    );

    modport peripheral (
        input  read,
        input  write,
        input  offset,
        input  writeData,
        output readData
    );

endinterface

//--- addressMap.sv
`timescale 1ns/100ps

module addressMap (
    input  logic [busPkg::ADDR_WIDTH-1:0]        address,
    output busPkg::busTarget_e                   target,
    output logic [busPkg::WORD_OFFSET_WIDTH-1:0] wordOffset
);
    import busPkg::*;

    // range match, one peripheral per window
    always_comb begin
        target = TARGET_NONE;

        if ((address >= RAM_BASE) && (address <= RAM_LAST)) begin
            target = TARGET_RAM;
        end
        if ((address >= RANDOM_BASE) && (address <= RANDOM_LAST)) begin
            target = TARGET_RANDOM;
        end
        if ((address >= TIMER_BASE) && (address <= TIMER_LAST)) begin
            target = TARGET_TIMER;
        end
        if ((address >= SLOW_BASE) && (address <= SLOW_LAST)) begin
            target = TARGET_SLOW;
        end
        if ((address >= IO_BASE) && (address <= IO_LAST)) begin
            target = TARGET_IO;
        end
    end

    // word address, byte lanes dropped
    assign wordOffset = address[WORD_OFFSET_WIDTH+1:2];

endmodule

//--- busController.sv
`timescale 1ns/100ps

module busController (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 read,
    input  logic                                 write,
    input  logic [busPkg::DATA_WIDTH-1:0]        writeData,
    input  busPkg::busTarget_e                   target,
    input  logic [busPkg::WORD_OFFSET_WIDTH-1:0] wordOffset,
    output logic [busPkg::DATA_WIDTH-1:0]        readData,
    output logic                                 waitRequest,
    peripheralBus.controller                     ramBus,
    peripheralBus.controller                     randomBus,
    peripheralBus.controller                     timerBus,
    peripheralBus.controller                     ioBus,
    output logic                                 slowStart,
    output logic                                 slowWriteNotRead,
    output logic [busPkg::WORD_OFFSET_WIDTH-1:0] slowOffset,
    output logic [busPkg::DATA_WIDTH-1:0]        slowWriteData,
    input  logic [busPkg::DATA_WIDTH-1:0]        slowReadData,
    input  logic                                 slowBusy
);
    import busPkg::*;

    busState_e  state;
    busState_e  nextState;
    busTarget_e readTarget;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= STATE_IDLE;
            readTarget <= TARGET_NONE;
        end else begin
            state <= nextState;
            // remember where the read data will come from
            if ((state == STATE_IDLE) && read) begin
                readTarget <= target;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            STATE_IDLE: begin
                if ((read || write) && (target == TARGET_SLOW)) begin
                    nextState = STATE_SLOW_WAIT;
                end else if (read) begin
                    nextState = STATE_READ_WAIT;
                end
            end
            STATE_READ_WAIT: nextState = STATE_IDLE;
            STATE_SLOW_WAIT: begin
                if (!slowBusy) begin
                    nextState = STATE_IDLE;
                end
            end
            default: nextState = STATE_IDLE;
        endcase
    end

    // strobes only leave the controller while idle
    always_comb begin
        ramBus.read     = 1'b0;
        ramBus.write    = 1'b0;
        randomBus.read  = 1'b0;
        randomBus.write = 1'b0;
        timerBus.read   = 1'b0;
        timerBus.write  = 1'b0;
        ioBus.read      = 1'b0;
        ioBus.write     = 1'b0;
        slowStart       = 1'b0;
        if (state == STATE_IDLE) begin
            case (target)
                TARGET_RAM: begin
                    ramBus.read  = read;
                    ramBus.write = write;
                end
                TARGET_RANDOM: begin
                    randomBus.read  = read;
                    randomBus.write = write;
                end
                TARGET_TIMER: begin
                    timerBus.read  = read;
                    timerBus.write = write;
                end
                TARGET_IO: begin
                    ioBus.read  = read;
                    ioBus.write = write;
                end
                TARGET_SLOW: slowStart = read || write;
                default: ;
            endcase
        end
    end

    assign ramBus.offset       = wordOffset[RAM_OFFSET_WIDTH-1:0];
    assign randomBus.offset    = wordOffset[RANDOM_OFFSET_WIDTH-1:0];
    assign timerBus.offset     = wordOffset[TIMER_OFFSET_WIDTH-1:0];
    assign ioBus.offset        = wordOffset[IO_OFFSET_WIDTH-1:0];
    assign ramBus.writeData    = writeData;
    assign randomBus.writeData = writeData;
    assign timerBus.writeData  = writeData;
    assign ioBus.writeData     = writeData;

    assign slowWriteNotRead = write;
    assign slowOffset       = wordOffset;
    assign slowWriteData    = writeData;

    // fast writes finish at once, every read waits at least one cycle
    always_comb begin
        case (state)
            STATE_IDLE:      waitRequest = read || (write && (target == TARGET_SLOW));
            STATE_READ_WAIT: waitRequest = 1'b0;
            STATE_SLOW_WAIT: waitRequest = slowBusy;
            default:         waitRequest = 1'b0;
        endcase
    end

    always_comb begin
        case (readTarget)
            TARGET_RAM:    readData = ramBus.readData;
            TARGET_RANDOM: readData = randomBus.readData;
            TARGET_TIMER:  readData = timerBus.readData;
            TARGET_IO:     readData = ioBus.readData;
            TARGET_SLOW:   readData = slowReadData;
            default:       readData = UNMAPPED_READ_VALUE;
        endcase
    end

endmodule

//--- ramBlock.sv
`timescale 1ns/100ps

module ramBlock #(
    parameter int RAM_DEPTH_LOG2 = 12
) (
    input  logic               clk,
    peripheralBus.peripheral   memBus
);
    import busPkg::*;

    localparam int RAM_WORDS = 1 << RAM_DEPTH_LOG2;

    logic [DATA_WIDTH-1:0]     mem [RAM_WORDS];
    logic [RAM_DEPTH_LOG2-1:0] wordIndex;

    assign wordIndex = memBus.offset[RAM_DEPTH_LOG2-1:0];

    // single port, read data registered on the strobe
    always_ff @(posedge clk) begin
        if (memBus.write) begin
            mem[wordIndex] <= memBus.writeData;
        end
        if (memBus.read) begin
            memBus.readData <= mem[wordIndex];
        end
    end

endmodule

//--- slowMemory.sv
`timescale 1ns/100ps

module slowMemory #(
    parameter int SLOW_DEPTH_LOG2  = 10,
    parameter int SLOW_WAIT_STATES = 3
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic                                 writeNotRead,
    input  logic [busPkg::WORD_OFFSET_WIDTH-1:0] offset,
    input  logic [busPkg::DATA_WIDTH-1:0]        writeData,
    output logic [busPkg::DATA_WIDTH-1:0]        readData,
    output logic                                 busy
);
    import busPkg::*;

    localparam int COUNT_WIDTH = $clog2(SLOW_WAIT_STATES + 1);

    logic [DATA_WIDTH-1:0]      mem [1 << SLOW_DEPTH_LOG2];
    logic [COUNT_WIDTH-1:0]     waitCount;
    logic                       cmdWrite;
    logic [SLOW_DEPTH_LOG2-1:0] cmdIndex;
    logic [DATA_WIDTH-1:0]      cmdData;
    logic                       lastCycle;

    // access happens in the final busy cycle
    assign lastCycle = busy && (waitCount == COUNT_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            waitCount <= '0;
        end else if (busy) begin
            waitCount <= waitCount - 1'b1;
            if (lastCycle) begin
                busy <= 1'b0;
            end
        end else if (start) begin
            busy      <= 1'b1;
            waitCount <= COUNT_WIDTH'(SLOW_WAIT_STATES);
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            cmdWrite <= writeNotRead;
            cmdIndex <= offset[SLOW_DEPTH_LOG2-1:0];
            cmdData  <= writeData;
        end
        if (lastCycle) begin
            if (cmdWrite) begin
                mem[cmdIndex] <= cmdData;
            end else begin
                readData <= mem[cmdIndex];
            end
        end
    end

endmodule

//--- timerBlock.sv
`timescale 1ns/100ps

module timerBlock (
    input  logic             clk,
    input  logic             rst,
    peripheralBus.peripheral regBus,
    output logic             irq
);
    import busPkg::*;

    logic                  enable;
    logic [DATA_WIDTH-1:0] count;
    logic [DATA_WIDTH-1:0] compare;
    logic                  status;
    logic                  controlWrite;

    assign controlWrite = regBus.write && (regBus.offset == TIMER_CONTROL);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable  <= 1'b0;
            count   <= '0;
            compare <= '0;
            status  <= 1'b0;
        end else begin
            if (controlWrite) begin
                enable <= regBus.writeData[0];
            end

            // a written count wins over the increment
            if (regBus.write && (regBus.offset == TIMER_COUNT)) begin
                count <= regBus.writeData;
            end else if (enable) begin
                count <= count + 1'b1;
            end

            if (regBus.write && (regBus.offset == TIMER_COMPARE)) begin
                compare <= regBus.writeData;
            end

            // sticky match flag, cleared through control bit 1
            if (controlWrite && regBus.writeData[1]) begin
                status <= 1'b0;
            end else if (enable && (count == compare)) begin
                status <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (regBus.read) begin
            case (regBus.offset)
                TIMER_CONTROL: regBus.readData <= {{(DATA_WIDTH-1){1'b0}}, enable};
                TIMER_COUNT:   regBus.readData <= count;
                TIMER_COMPARE: regBus.readData <= compare;
                TIMER_STATUS:  regBus.readData <= {{(DATA_WIDTH-1){1'b0}}, status};
                default:       regBus.readData <= '0;
            endcase
        end
    end

    assign irq = status;

endmodule

//--- randomGenerator.sv
`timescale 1ns/100ps

module randomGenerator #(
    parameter logic [31:0] LFSR_RESET_SEED = 32'hACE1_2025
) (
    input  logic             clk,
    input  logic             rst,
    peripheralBus.peripheral regBus
);

    logic [31:0] lfsr;
    logic        feedback;

    // taps 31, 21, 1, 0
    assign feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_RESET_SEED;
        end else if (regBus.write) begin
            // all-zero state would lock up
            lfsr <= (regBus.writeData == '0) ? LFSR_RESET_SEED : regBus.writeData;
        end else if (regBus.read) begin
            lfsr <= {lfsr[30:0], feedback};
        end
    end

    // value seen by the host is the state before the step
    always_ff @(posedge clk) begin
        if (regBus.read) begin
            regBus.readData <= lfsr;
        end
    end

endmodule

//--- ioPort.sv
`timescale 1ns/100ps

module ioPort (
    input  logic             clk,
    input  logic             rst,
    peripheralBus.peripheral regBus,
    input  logic [7:0]       ioIn,
    output logic [7:0]       ioOut
);
    import busPkg::*;

    logic [7:0] ioMeta;
    logic [7:0] ioSync;

    always_ff @(posedge clk) begin
        if (rst) begin
            ioOut <= '0;
        end else if (regBus.write) begin
            ioOut <= regBus.writeData[7:0];
        end
    end

    // two-stage synchronizer for the asynchronous inputs
    always_ff @(posedge clk) begin
        ioMeta <= ioIn;
        ioSync <= ioMeta;
        if (regBus.read) begin
            regBus.readData <= {{(DATA_WIDTH-8){1'b0}}, ioSync};
        end
    end

endmodule

//--- soundBusTop.sv
`timescale 1ns/100ps

module soundBusTop #(
    parameter int          RAM_DEPTH_LOG2   = 12,
    parameter int          SLOW_DEPTH_LOG2  = 10,
    parameter int          SLOW_WAIT_STATES = 3,
    parameter logic [31:0] LFSR_RESET_SEED  = 32'hACE1_2025
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [busPkg::ADDR_WIDTH-1:0] address,
    input  logic                          read,
    input  logic                          write,
    input  logic [busPkg::DATA_WIDTH-1:0] writeData,
    output logic [busPkg::DATA_WIDTH-1:0] readData,
    output logic                          waitRequest,
    input  logic [7:0]                    ioIn,
    output logic [7:0]                    ioOut,
    output logic                          timerIrq
);
    import busPkg::*;

    busTarget_e                   target;
    logic [WORD_OFFSET_WIDTH-1:0] wordOffset;
    logic                         slowStart;
    logic                         slowWriteNotRead;
    logic [WORD_OFFSET_WIDTH-1:0] slowOffset;
    logic [DATA_WIDTH-1:0]        slowWriteData;
    logic [DATA_WIDTH-1:0]        slowReadData;
    logic                         slowBusy;

    peripheralBus #(.OFFSET_WIDTH(RAM_OFFSET_WIDTH))    ramBus ();
    peripheralBus #(.OFFSET_WIDTH(RANDOM_OFFSET_WIDTH)) randomBus ();
    peripheralBus #(.OFFSET_WIDTH(TIMER_OFFSET_WIDTH))  timerBus ();
    peripheralBus #(.OFFSET_WIDTH(IO_OFFSET_WIDTH))     ioBus ();

    addressMap addressMapInst (
        .address    (address),
        .target     (target),
        .wordOffset (wordOffset)
    );

    busController busControllerInst (
        .clk              (clk),
        .rst              (rst),
        .read             (read),
        .write            (write),
        .writeData        (writeData),
        .target           (target),
        .wordOffset       (wordOffset),
        .readData         (readData),
        .waitRequest      (waitRequest),
        .ramBus           (ramBus.controller),
        .randomBus        (randomBus.controller),
        .timerBus         (timerBus.controller),
        .ioBus            (ioBus.controller),
        .slowStart        (slowStart),
        .slowWriteNotRead (slowWriteNotRead),
        .slowOffset       (slowOffset),
        .slowWriteData    (slowWriteData),
        .slowReadData     (slowReadData),
        .slowBusy         (slowBusy)
    );

    ramBlock #(.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)) ramInst (
        .clk    (clk),
        .memBus (ramBus.peripheral)
    );

    slowMemory #(
        .SLOW_DEPTH_LOG2  (SLOW_DEPTH_LOG2),
        .SLOW_WAIT_STATES (SLOW_WAIT_STATES)
    ) slowMemoryInst (
        .clk          (clk),
        .rst          (rst),
        .start        (slowStart),
        .writeNotRead (slowWriteNotRead),
        .offset       (slowOffset),
        .writeData    (slowWriteData),
        .readData     (slowReadData),
        .busy         (slowBusy)
    );

    timerBlock timerInst (
        .clk    (clk),
        .rst    (rst),
        .regBus (timerBus.peripheral),
        .irq    (timerIrq)
    );

    randomGenerator #(.LFSR_RESET_SEED(LFSR_RESET_SEED)) randomInst (
        .clk    (clk),
        .rst    (rst),
        .regBus (randomBus.peripheral)
    );

    ioPort ioInst (
        .clk    (clk),
        .rst    (rst),
        .regBus (ioBus.peripheral),
        .ioIn   (ioIn),
        .ioOut  (ioOut)
    );

endmodule

//--- soundBusTb.sv
`timescale 1ns/100ps

module soundBusTb;
    import busPkg::*;

    localparam int          CLK_PERIOD       = 8;
    localparam int          RAM_DEPTH_LOG2   = 12;
    localparam int          SLOW_DEPTH_LOG2  = 10;
    localparam int          SLOW_WAIT_STATES = 3;
    localparam logic [31:0] LFSR_RESET_SEED  = 32'hACE1_2025;
    localparam int          RANDOM_SEED      = 92302;
    localparam int          MAX_WAIT_CYCLES  = 64;
    localparam int          TIMER_MATCH      = 20;
    localparam int          RAM_WORDS        = 1 << RAM_DEPTH_LOG2;
    localparam int          SLOW_WORDS       = 1 << SLOW_DEPTH_LOG2;

    // cycle cost of each test, transfers plus the gap between them
    localparam int SLOW_ACCESS_CYCLES = SLOW_WAIT_STATES + 3;
    localparam int RESET_CYCLES       = 6;
    localparam int RAM_CYCLES         = 32 * 2 + 32 * 3;
    localparam int SLOW_CYCLES        = 12 * SLOW_ACCESS_CYCLES;
    localparam int RANDOM_CYCLES      = 20 * 3;
    localparam int TIMER_CYCLES       = TIMER_MATCH + 30;
    localparam int IO_CYCLES          = 40;
    localparam int MARGIN_CYCLES      = 100;
    localparam int CYCLE_BUDGET       = RESET_CYCLES + RAM_CYCLES + SLOW_CYCLES
                                      + RANDOM_CYCLES + TIMER_CYCLES + IO_CYCLES;

    logic        clk;
    logic        rst;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic        waitRequest;
    logic [7:0]  ioIn;
    logic [7:0]  ioOut;
    logic        timerIrq;

    soundBusTop #(
        .RAM_DEPTH_LOG2   (RAM_DEPTH_LOG2),
        .SLOW_DEPTH_LOG2  (SLOW_DEPTH_LOG2),
        .SLOW_WAIT_STATES (SLOW_WAIT_STATES),
        .LFSR_RESET_SEED  (LFSR_RESET_SEED)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .read        (read),
        .write       (write),
        .writeData   (writeData),
        .readData    (readData),
        .waitRequest (waitRequest),
        .ioIn        (ioIn),
        .ioOut       (ioOut),
        .timerIrq    (timerIrq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        stopWithFailure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected));
    endtask

    initial begin
        #((CYCLE_BUDGET + MARGIN_CYCLES) * CLK_PERIOD);
        stopWithFailure("Timeout: the tests did not finish in the expected time");
    end

    // request is held until the first mid-cycle sample with waitRequest low
    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                            output int waitCycles);
        @(posedge clk);
        address   <= addr;
        writeData <= data;
        write     <= 1'b1;
        waitCycles = 0;
        @(negedge clk);
        while (waitRequest && (waitCycles < MAX_WAIT_CYCLES)) begin
            waitCycles++;
            @(negedge clk);
        end
        assert (!waitRequest) else
            stopWithFailure($sformatf("Write to 0x%08h never completed", addr));
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data,
                           output int waitCycles);
        @(posedge clk);
        address <= addr;
        read    <= 1'b1;
        waitCycles = 0;
        @(negedge clk);
        while (waitRequest && (waitCycles < MAX_WAIT_CYCLES)) begin
            waitCycles++;
            @(negedge clk);
        end
        assert (!waitRequest) else
            stopWithFailure($sformatf("Read from 0x%08h never completed", addr));
        data = readData;
        @(posedge clk);
        read <= 1'b0;
    endtask

    // fibonacci step, taps 31 21 1 0 into bit 0
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] timerAddress(input logic [2:0] offset);
        return TIMER_BASE + {27'd0, offset, 2'b00};
    endfunction

    task automatic ramReadback();
        logic [31:0] shadow [RAM_WORDS];
        int          indexList [32];
        logic [31:0] data;
        int          cycles;
        for (int i = 0; i < 32; i++) begin
            indexList[i] = $urandom_range(RAM_WORDS - 1, 0);
            data = $urandom;
            shadow[indexList[i]] = data;
            busWrite(RAM_BASE + 4 * indexList[i], data, cycles);
            assert (cycles == 0) else reportMismatch("RAM write waitRequest cycles", cycles, 0);
        end
        for (int i = 0; i < 32; i++) begin
            busRead(RAM_BASE + 4 * indexList[i], data, cycles);
            assert (data === shadow[indexList[i]]) else
                reportMismatch("RAM readData", data, shadow[indexList[i]]);
            assert (cycles == 1) else reportMismatch("RAM read waitRequest cycles", cycles, 1);
        end
    endtask

    task automatic slowMemoryAccess();
        int          indexList [4];
        logic [31:0] values [4];
        logic [31:0] aliasValue;
        logic [31:0] data;
        int          cycles;
        // one index per quarter, so no two collide
        for (int i = 0; i < 4; i++) begin
            indexList[i] = i * (SLOW_WORDS / 4) + $urandom_range(SLOW_WORDS / 4 - 1, 0);
            values[i] = $urandom;
            busWrite(SLOW_BASE + 4 * indexList[i], values[i], cycles);
            assert (cycles == SLOW_WAIT_STATES + 1) else
                reportMismatch("slow write waitRequest cycles", cycles, SLOW_WAIT_STATES + 1);
        end
        for (int i = 0; i < 4; i++) begin
            busRead(SLOW_BASE + 4 * indexList[i], data, cycles);
            assert (data === values[i]) else reportMismatch("slow readData", data, values[i]);
            assert (cycles == SLOW_WAIT_STATES + 1) else
                reportMismatch("slow read waitRequest cycles", cycles, SLOW_WAIT_STATES + 1);
        end
        // one memory size higher lands on the same word
        aliasValue = ~values[0];
        busWrite(SLOW_BASE + 4 * indexList[0] + 4 * SLOW_WORDS, aliasValue, cycles);
        busRead(SLOW_BASE + 4 * indexList[0], data, cycles);
        assert (data === aliasValue) else reportMismatch("slow alias readData", data, aliasValue);
        busRead(SLOW_BASE + 4 * indexList[1] + 4 * SLOW_WORDS, data, cycles);
        assert (data === values[1]) else reportMismatch("slow alias readData", data, values[1]);
    endtask

    task automatic randomSequence();
        logic [31:0] model;
        logic [31:0] data;
        int          cycles;
        busRead(RANDOM_BASE, data, cycles);
        assert (data === LFSR_RESET_SEED) else
            reportMismatch("random readData after reset", data, LFSR_RESET_SEED);
        model = $urandom | 32'h1;
        busWrite(RANDOM_BASE, model, cycles);
        repeat (16) begin
            busRead(RANDOM_BASE, data, cycles);
            assert (data === model) else reportMismatch("random readData", data, model);
            assert (cycles == 1) else reportMismatch("random read waitRequest cycles", cycles, 1);
            model = lfsrNext(model);
        end
        // zero seed falls back to the reset seed
        busWrite(RANDOM_BASE, 32'h0, cycles);
        busRead(RANDOM_BASE, data, cycles);
        assert (data === LFSR_RESET_SEED) else
            reportMismatch("random readData after zero seed", data, LFSR_RESET_SEED);
    endtask

    task automatic timerInterrupt();
        logic [31:0] data;
        int          cycles;
        int          waited;
        busWrite(timerAddress(TIMER_COUNT), 32'h0, cycles);
        busWrite(timerAddress(TIMER_COMPARE), TIMER_MATCH, cycles);
        @(negedge clk);
        assert (timerIrq === 1'b0) else reportMismatch("timerIrq before enable", timerIrq, 0);
        busWrite(timerAddress(TIMER_CONTROL), 32'h1, cycles);
        waited = 0;
        @(negedge clk);
        while (!timerIrq && (waited < TIMER_MATCH + 4)) begin
            waited++;
            @(negedge clk);
        end
        assert (timerIrq === 1'b1) else
            stopWithFailure("timerIrq did not rise within compare plus 4 cycles");
        repeat (8) begin
            @(negedge clk);
            assert (timerIrq === 1'b1) else stopWithFailure("timerIrq dropped before a clear");
        end
        busRead(timerAddress(TIMER_STATUS), data, cycles);
        assert (data === 32'h1) else reportMismatch("timer status readData", data, 32'h1);
        // bit 1 clears the flag, bit 0 low stops the count
        busWrite(timerAddress(TIMER_CONTROL), 32'h2, cycles);
        @(negedge clk);
        assert (timerIrq === 1'b0) else reportMismatch("timerIrq after clear", timerIrq, 0);
    endtask

    task automatic ioAndUnmapped();
        logic [31:0] data;
        logic [7:0]  inValue;
        int          cycles;
        busWrite(IO_BASE, 32'h0000_005A, cycles);
        @(negedge clk);
        assert (ioOut === 8'h5A) else reportMismatch("ioOut", ioOut, 8'h5A);
        busWrite(IO_BASE, 32'hDEAD_BEA5, cycles);
        @(negedge clk);
        assert (ioOut === 8'hA5) else reportMismatch("ioOut", ioOut, 8'hA5);

        inValue = $urandom_range(255, 0);
        @(posedge clk);
        ioIn <= inValue;
        // let the synchronizer settle
        repeat (3) @(posedge clk);
        busRead(IO_BASE, data, cycles);
        assert (data === {24'h0, inValue}) else reportMismatch("io readData", data, inValue);

        busRead(32'h0000_4010, data, cycles);
        assert (data === UNMAPPED_READ_VALUE) else
            reportMismatch("unmapped readData", data, UNMAPPED_READ_VALUE);
        assert (cycles == 1) else reportMismatch("unmapped read waitRequest cycles", cycles, 1);
        busRead(32'h0300_1000, data, cycles);
        assert (data === UNMAPPED_READ_VALUE) else
            reportMismatch("unmapped readData", data, UNMAPPED_READ_VALUE);

        // 0x4010 would hit RAM word 4 if the decode leaked
        busWrite(RAM_BASE + 32'h10, 32'h1234_5678, cycles);
        busWrite(32'h0000_4010, 32'hFFFF_FFFF, cycles);
        assert (cycles == 0) else reportMismatch("unmapped write waitRequest cycles", cycles, 0);
        busWrite(32'h0300_1000, 32'h0000_0033, cycles);
        busRead(RAM_BASE + 32'h10, data, cycles);
        assert (data === 32'h1234_5678) else reportMismatch("RAM readData", data, 32'h1234_5678);
        @(negedge clk);
        assert (ioOut === 8'hA5) else reportMismatch("ioOut after unmapped write", ioOut, 8'hA5);
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        rst       = 1'b1;
        address   = '0;
        read      = 1'b0;
        write     = 1'b0;
        writeData = '0;
        ioIn      = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (waitRequest === 1'b0) else reportMismatch("waitRequest after reset", waitRequest, 0);
        assert (ioOut === 8'h00) else reportMismatch("ioOut after reset", ioOut, 0);
        assert (timerIrq === 1'b0) else reportMismatch("timerIrq after reset", timerIrq, 0);

        ramReadback();
        slowMemoryAccess();
        randomSequence();
        timerInterrupt();
        ioAndUnmapped();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- soundBusTop.f
busPkg.sv
peripheralBus.sv
addressMap.sv
busController.sv
ramBlock.sv
slowMemory.sv
timerBlock.sv
randomGenerator.sv
ioPort.sv
soundBusTop.sv
soundBusTb.sv
